//--- backEnd.sv
`include "cpu_params.svh"

module backEnd import pipe_pkg::*; (
	input logic clka,
	input logic arstN_i,
	input logic [`DATA_W-1:0] pcE_i,
	input logic [`DATA_W-1:0] rd1E_i,
	input logic [`DATA_W-1:0] rd2E_i,
	input logic [`DATA_W-1:0] immE_i,
	input logic [`REG_AW-1:0] rtE_i,
	input logic [`REG_AW-1:0] rdE_i,
	input logic [4:0] shamtE_i,
	input aluOpT aluOpE_i,
	input logic aluSrcE_i,
	input logic regDstE_i,
	input logic regWriteE_i,
	input logic memToRegE_i,
	input logic memWriteE_i,
	input fwdSelT fwdAE_i,
	input fwdSelT fwdBE_i,
	output logic [`DATA_W-1:0] aluOutM_o,
	output logic regWriteW_o,
	output logic [`REG_AW-1:0] writeRegW_o,
	output logic [`DATA_W-1:0] resultW_o,
	output logic [`REG_AW-1:0] writeRegE_o,
	output logic [`REG_AW-1:0] writeRegM_o,
	output logic regWriteM_o,
	output logic memToRegM_o,
	output logic [`DATA_W-1:0] dmemAddr_o,
	output logic [`DATA_W-1:0] dmemWdata_o,
	output logic dmemWe_o,
	input logic [`DATA_W-1:0] dmemRdata_i,
	output logic wbValid_o,
	output logic [`DATA_W-1:0] wbPc_o
);

	logic [`DATA_W-1:0] srcAE, srcBE, writeDataE, aluOutE;
	logic [`DATA_W-1:0] writeDataM, pcM, aluOutW, readDataW, pcW;
	logic memWriteM, memToRegW;

	function automatic logic [`DATA_W-1:0] fwdMux(input fwdSelT sel,
			input logic [`DATA_W-1:0] regVal, wbVal, memVal);
		case (sel)
			fromMem: return memVal; // youngest value wins
			fromWb: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ------------------------------
	// execute
	assign srcAE = fwdMux(fwdAE_i, rd1E_i, resultW_o, aluOutM_o);
	assign writeDataE = fwdMux(fwdBE_i, rd2E_i, resultW_o, aluOutM_o); // also the sw data
	assign srcBE = aluSrcE_i ? immE_i : writeDataE;

	always_comb begin
		case (aluOpE_i)
			aluAdd: aluOutE = srcAE + srcBE; // wraps, no overflow trap
			aluSub: aluOutE = srcAE - srcBE;
			aluAnd: aluOutE = srcAE & srcBE;
			aluOr: aluOutE = srcAE | srcBE;
			aluSlt: aluOutE = {{(`DATA_W-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
			aluSll: aluOutE = srcBE << shamtE_i; // rt shifted, rs ignored
			default: aluOutE = '0;
		endcase
	end

	assign writeRegE_o = regDstE_i ? rdE_i : rtE_i;

	// execute/memory register
	always_ff @(posedge clka or negedge arstN_i) begin
		if (!arstN_i) begin
			{regWriteM_o, memToRegM_o, memWriteM} <= '0;
			{aluOutM_o, writeDataM, writeRegM_o, pcM} <= '0;
		end else begin
			regWriteM_o <= regWriteE_i;
			memToRegM_o <= memToRegE_i;
			memWriteM <= memWriteE_i;
			aluOutM_o <= aluOutE;
			writeDataM <= writeDataE;
			writeRegM_o <= writeRegE_o;
			pcM <= pcE_i;
		end
	end

	// ------------------------------
	// memory
	assign dmemAddr_o = aluOutM_o;
	assign dmemWdata_o = writeDataM;
	assign dmemWe_o = memWriteM;

	// memory/writeback register
	always_ff @(posedge clka or negedge arstN_i) begin
		if (!arstN_i) begin
			{regWriteW_o, memToRegW} <= '0;
			{aluOutW, readDataW, writeRegW_o, pcW} <= '0;
		end else begin
			regWriteW_o <= regWriteM_o;
			memToRegW <= memToRegM_o;
			aluOutW <= aluOutM_o;
			readDataW <= dmemRdata_i; // read is combinational, sample here
			writeRegW_o <= writeRegM_o;
			pcW <= pcM;
		end
	end

	// writeback
	assign resultW_o = memToRegW ? readDataW : aluOutW;
	assign wbValid_o = regWriteW_o && (writeRegW_o != '0); // r0 writes retire silently
	assign wbPc_o = pcW;

endmodule

//--- cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath width
`define DATA_W 32

// register file geometry
`define REG_AW 5
`define REG_N 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- frontEnd.sv
`include "cpu_params.svh"

module frontEnd import isa_pkg::*, pipe_pkg::*; (
	input logic clka,
	input logic arstN_i,
	output logic [`DATA_W-1:0] imemAddr_o,
	input logic [`DATA_W-1:0] imemData_i,
	input logic stallF_i,
	input logic stallD_i,
	input logic bubbleE_i,
	input logic fwdAD_i,
	input logic fwdBD_i,
	input logic [`DATA_W-1:0] aluOutM_i,
	input logic regWriteW_i,
	input logic [`REG_AW-1:0] writeRegW_i,
	input logic [`DATA_W-1:0] resultW_i,
	output logic [`REG_AW-1:0] rsD_o,
	output logic [`REG_AW-1:0] rtD_o,
	output logic branchD_o,
	output logic usesRtD_o,
	output logic [`DATA_W-1:0] pcE_o,
	output logic [`DATA_W-1:0] rd1E_o,
	output logic [`DATA_W-1:0] rd2E_o,
	output logic [`DATA_W-1:0] immE_o,
	output logic [`REG_AW-1:0] rsE_o,
	output logic [`REG_AW-1:0] rtE_o,
	output logic [`REG_AW-1:0] rdE_o,
	output logic [4:0] shamtE_o,
	output aluOpT aluOpE_o,
	output logic aluSrcE_o,
	output logic regDstE_o,
	output logic regWriteE_o,
	output logic memToRegE_o,
	output logic memWriteE_o
);

	logic [`DATA_W-1:0] pcF, pcPlus4F, pcNext, pcD, pcPlus4D;
	logic [`DATA_W-1:0] rfRd1, rfRd2, rd1D, rd2D, immD, branchTgt, jumpTgt;
	instrT instrD;
	logic regWriteD, memToRegD, memWriteD, aluSrcD, regDstD, zeroExtD;
	logic branchD, branchNeD, jumpD, takenD;
	aluOpT aluOpD;

	// ------------------------------
	// fetch
	assign pcPlus4F = pcF + 32'd4;
	assign imemAddr_o = pcF;

	always_ff @(posedge clka or negedge arstN_i) begin
		if (!arstN_i) begin
			pcF <= `RESET_PC;
		end else if (!stallF_i) begin
			pcF <= pcNext;
		end
	end

	// fetch/decode register, no flush since the delay slot always runs
	always_ff @(posedge clka or negedge arstN_i) begin
		if (!arstN_i) begin
			instrD <= '0; // sll r0 = nop
			pcD <= '0;
		end else if (!stallD_i) begin
			instrD <= imemData_i;
			pcD <= pcF;
		end
	end

	// ------------------------------
	// decode
	instrDecoder instrDecoder_inst (
		.instr_i(instrD),
		.regWrite_o(regWriteD),
		.memToReg_o(memToRegD),
		.memWrite_o(memWriteD),
		.aluSrc_o(aluSrcD),
		.regDst_o(regDstD),
		.zeroExt_o(zeroExtD),
		.branch_o(branchD),
		.branchNe_o(branchNeD),
		.jump_o(jumpD),
		.aluOp_o(aluOpD)
	);

	regFile regFile_inst (
		.clka(clka),
		.we_i(regWriteW_i),
		.ra1_i(instrD.r.rs),
		.ra2_i(instrD.r.rt),
		.wa_i(writeRegW_i),
		.wd_i(resultW_i),
		.rd1_o(rfRd1),
		.rd2_o(rfRd2)
	);

	assign rd1D = fwdAD_i ? aluOutM_i : rfRd1; // mem stage bypass for the compare
	assign rd2D = fwdBD_i ? aluOutM_i : rfRd2;
	assign immD = zeroExtD ? {16'b0, instrD.i.imm} : {{16{instrD.i.imm[15]}}, instrD.i.imm};

	// next pc, both targets relative to the delay slot
	assign pcPlus4D = pcD + 32'd4;
	assign branchTgt = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTgt = {pcPlus4D[31:28], instrD.j.target, 2'b00};
	assign takenD = branchD & ((rd1D == rd2D) ^ branchNeD);
	assign pcNext = jumpD ? jumpTgt : (takenD ? branchTgt : pcPlus4F);

	// hazard info
	assign rsD_o = instrD.r.rs;
	assign rtD_o = instrD.r.rt;
	assign branchD_o = branchD;
	assign usesRtD_o = ~aluSrcD | memWriteD; // R-type, branches and sw read rt

	// ------------------------------
	// decode/execute register, a bubble is a full no-op
	always_ff @(posedge clka or negedge arstN_i) begin
		if (!arstN_i) begin
			{pcE_o, rd1E_o, rd2E_o, immE_o, rsE_o, rtE_o, rdE_o, shamtE_o} <= '0;
			{aluSrcE_o, regDstE_o, regWriteE_o, memToRegE_o, memWriteE_o} <= '0;
			aluOpE_o <= aluAdd;
		end else if (bubbleE_i) begin
			{pcE_o, rd1E_o, rd2E_o, immE_o, rsE_o, rtE_o, rdE_o, shamtE_o} <= '0;
			{aluSrcE_o, regDstE_o, regWriteE_o, memToRegE_o, memWriteE_o} <= '0;
			aluOpE_o <= aluAdd;
		end else begin
			pcE_o <= pcD;
			rd1E_o <= rd1D;
			rd2E_o <= rd2D;
			immE_o <= immD;
			rsE_o <= instrD.r.rs;
			rtE_o <= instrD.r.rt;
			rdE_o <= instrD.r.rd;
			shamtE_o <= instrD.r.shamt;
			aluOpE_o <= aluOpD;
			aluSrcE_o <= aluSrcD;
			regDstE_o <= regDstD;
			regWriteE_o <= regWriteD;
			memToRegE_o <= memToRegD;
			memWriteE_o <= memWriteD;
		end
	end

endmodule

//--- hazardUnit.sv
`include "cpu_params.svh"

module hazardUnit import pipe_pkg::*; (
	input logic [`REG_AW-1:0] rsD_i,
	input logic [`REG_AW-1:0] rtD_i,
	input logic branchD_i,
	input logic usesRtD_i,
	input logic [`REG_AW-1:0] rsE_i,
	input logic [`REG_AW-1:0] rtE_i,
	input logic [`REG_AW-1:0] writeRegE_i,
	input logic regWriteE_i,
	input logic memToRegE_i,
	input logic [`REG_AW-1:0] writeRegM_i,
	input logic regWriteM_i,
	input logic memToRegM_i,
	input logic [`REG_AW-1:0] writeRegW_i,
	input logic regWriteW_i,
	output logic stallF_o,
	output logic stallD_o,
	output logic bubbleE_o,
	output fwdSelT fwdAE_o,
	output fwdSelT fwdBE_o,
	output logic fwdAD_o,
	output logic fwdBD_o
);

	logic loadUse, branchOnE, branchOnLoadM, stall;

	function automatic fwdSelT fwdSel(input logic [`REG_AW-1:0] src);
		if (src == '0) return fromReg; // r0 is constant
		if (regWriteM_i && src == writeRegM_i) return fromMem;
		if (regWriteW_i && src == writeRegW_i) return fromWb;
		return fromReg;
	endfunction

	// execute bypass, memory checked before writeback
	assign fwdAE_o = fwdSel(rsE_i);
	assign fwdBE_o = fwdSel(rtE_i);

	// decode compare bypass, only a branch needs it
	assign fwdAD_o = branchD_i && rsD_i != '0 && regWriteM_i && rsD_i == writeRegM_i;
	assign fwdBD_o = branchD_i && rtD_i != '0 && regWriteM_i && rtD_i == writeRegM_i;

	// ------------------------------
	// stalls
	assign loadUse = memToRegE_i && writeRegE_i != '0 &&
		(rsD_i == writeRegE_i || (usesRtD_i && rtD_i == writeRegE_i));
	assign branchOnE = branchD_i && regWriteE_i && writeRegE_i != '0 &&
		(rsD_i == writeRegE_i || rtD_i == writeRegE_i); // result not ready yet
	assign branchOnLoadM = branchD_i && memToRegM_i && writeRegM_i != '0 &&
		(rsD_i == writeRegM_i || rtD_i == writeRegM_i); // load data only in writeback
	assign stall = loadUse | branchOnE | branchOnLoadM;

	assign stallF_o = stall;
	assign stallD_o = stall;
	assign bubbleE_o = stall; // decode instruction waits, execute gets a no-op

endmodule

//--- instrDecoder.sv
module instrDecoder import isa_pkg::*, pipe_pkg::*; (
	input instrT instr_i,
	output logic regWrite_o,
	output logic memToReg_o,
	output logic memWrite_o,
	output logic aluSrc_o, // 1: immediate as operand B
	output logic regDst_o, // 1: rd, 0: rt
	output logic zeroExt_o,
	output logic branch_o,
	output logic branchNe_o,
	output logic jump_o,
	output aluOpT aluOp_o
);

	always_comb begin
		// defaults give a no-op, nothing written
		regWrite_o = 1'b0;
		memToReg_o = 1'b0;
		memWrite_o = 1'b0;
		aluSrc_o = 1'b0;
		regDst_o = 1'b0;
		zeroExt_o = 1'b0;
		branch_o = 1'b0;
		branchNe_o = 1'b0;
		jump_o = 1'b0;
		aluOp_o = aluAdd;
		case (instr_i.r.op)
			SPECIAL: begin
				regDst_o = 1'b1;
				regWrite_o = 1'b1;
				case (instr_i.r.funct)
					ADDU: aluOp_o = aluAdd;
					SUBU: aluOp_o = aluSub;
					AND: aluOp_o = aluAnd;
					OR: aluOp_o = aluOr;
					SLT: aluOp_o = aluSlt;
					SLL: aluOp_o = aluSll;
					default: regWrite_o = 1'b0; // unsupported funct
				endcase
			end
			ADDIU: begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
			end
			ANDI, ORI: begin
				regWrite_o = 1'b1;
				aluSrc_o = 1'b1;
				zeroExt_o = 1'b1; // logical immediates are unsigned
				aluOp_o = (instr_i.r.op == ANDI) ? aluAnd : aluOr;
			end
			LW: begin
				regWrite_o = 1'b1;
				memToReg_o = 1'b1;
				aluSrc_o = 1'b1; // base + offset
			end
			SW: begin
				memWrite_o = 1'b1;
				aluSrc_o = 1'b1;
			end
			BEQ: branch_o = 1'b1;
			BNE: begin
				branch_o = 1'b1;
				branchNe_o = 1'b1;
			end
			J: jump_o = 1'b1;
			default: ; // unknown opcode stays a no-op
		endcase
	end

endmodule

//--- isa_pkg.sv
`include "cpu_params.svh"

package isa_pkg;

	// primary opcodes, only the supported subset
	typedef enum logic [5:0] {
		SPECIAL = 6'h00, // R-type, funct decides
		J = 6'h02,
		BEQ = 6'h04,
		BNE = 6'h05,
		ADDIU = 6'h09,
		ANDI = 6'h0c,
		ORI = 6'h0d,
		LW = 6'h23,
		SW = 6'h2b
	} opcodeT;

	// funct field of SPECIAL
	typedef enum logic [5:0] {
		SLL = 6'h00, // shift by shamt
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND = 6'h24,
		OR = 6'h25,
		SLT = 6'h2a
	} functT;

	// one instruction word, three views of it
	typedef union packed {
		struct packed {
			opcodeT op;
			logic [`REG_AW-1:0] rs;
			logic [`REG_AW-1:0] rt;
			logic [`REG_AW-1:0] rd;
			logic [4:0] shamt;
			functT funct;
		} r;
		struct packed {
			opcodeT op;
			logic [`REG_AW-1:0] rs;
			logic [`REG_AW-1:0] rt;
			logic [15:0] imm;
		} i;
		struct packed {
			opcodeT op;
			logic [25:0] target; // word index inside the 256MB region
		} j;
	} instrT;

endpackage

//--- mipsCore.sv
`include "cpu_params.svh"

module mipsCore import pipe_pkg::*; (
	input logic clka,
	input logic arstN_i,
	output logic [`DATA_W-1:0] imemAddr_o,
	input logic [`DATA_W-1:0] imemData_i,
	output logic [`DATA_W-1:0] dmemAddr_o,
	output logic [`DATA_W-1:0] dmemWdata_o,
	output logic dmemWe_o,
	input logic [`DATA_W-1:0] dmemRdata_i,
	output logic wbValid_o,
	output logic [`DATA_W-1:0] wbPc_o,
	output logic [`REG_AW-1:0] wbRegNum_o,
	output logic [`DATA_W-1:0] wbData_o
);

	// hazard controls
	logic stallF, stallD, bubbleE, fwdAD, fwdBD;
	fwdSelT fwdAE, fwdBE;
	// decode
	logic [`REG_AW-1:0] rsD, rtD;
	logic branchD, usesRtD;
	// execute
	logic [`DATA_W-1:0] pcE, rd1E, rd2E, immE;
	logic [`REG_AW-1:0] rsE, rtE, rdE, writeRegE;
	logic [4:0] shamtE;
	aluOpT aluOpE;
	logic aluSrcE, regDstE, regWriteE, memToRegE, memWriteE;
	// memory and writeback
	logic [`DATA_W-1:0] aluOutM, resultW;
	logic [`REG_AW-1:0] writeRegM, writeRegW;
	logic regWriteM, memToRegM, regWriteW;

	frontEnd frontEnd_inst (
		.clka(clka), .arstN_i(arstN_i),
		.imemAddr_o(imemAddr_o), .imemData_i(imemData_i),
		.stallF_i(stallF), .stallD_i(stallD), .bubbleE_i(bubbleE),
		.fwdAD_i(fwdAD), .fwdBD_i(fwdBD),
		.aluOutM_i(aluOutM), .regWriteW_i(regWriteW),
		.writeRegW_i(writeRegW), .resultW_i(resultW),
		.rsD_o(rsD), .rtD_o(rtD), .branchD_o(branchD), .usesRtD_o(usesRtD),
		.pcE_o(pcE), .rd1E_o(rd1E), .rd2E_o(rd2E), .immE_o(immE),
		.rsE_o(rsE), .rtE_o(rtE), .rdE_o(rdE), .shamtE_o(shamtE),
		.aluOpE_o(aluOpE), .aluSrcE_o(aluSrcE), .regDstE_o(regDstE),
		.regWriteE_o(regWriteE), .memToRegE_o(memToRegE), .memWriteE_o(memWriteE)
	);

	backEnd backEnd_inst (
		.clka(clka), .arstN_i(arstN_i),
		.pcE_i(pcE), .rd1E_i(rd1E), .rd2E_i(rd2E), .immE_i(immE),
		.rtE_i(rtE), .rdE_i(rdE), .shamtE_i(shamtE), .aluOpE_i(aluOpE),
		.aluSrcE_i(aluSrcE), .regDstE_i(regDstE), .regWriteE_i(regWriteE),
		.memToRegE_i(memToRegE), .memWriteE_i(memWriteE),
		.fwdAE_i(fwdAE), .fwdBE_i(fwdBE),
		.aluOutM_o(aluOutM), .regWriteW_o(regWriteW),
		.writeRegW_o(writeRegW), .resultW_o(resultW),
		.writeRegE_o(writeRegE), .writeRegM_o(writeRegM),
		.regWriteM_o(regWriteM), .memToRegM_o(memToRegM),
		.dmemAddr_o(dmemAddr_o), .dmemWdata_o(dmemWdata_o),
		.dmemWe_o(dmemWe_o), .dmemRdata_i(dmemRdata_i),
		.wbValid_o(wbValid_o), .wbPc_o(wbPc_o)
	);

	hazardUnit hazardUnit_inst (
		.rsD_i(rsD), .rtD_i(rtD), .branchD_i(branchD), .usesRtD_i(usesRtD),
		.rsE_i(rsE), .rtE_i(rtE), .writeRegE_i(writeRegE),
		.regWriteE_i(regWriteE), .memToRegE_i(memToRegE),
		.writeRegM_i(writeRegM), .regWriteM_i(regWriteM), .memToRegM_i(memToRegM),
		.writeRegW_i(writeRegW), .regWriteW_i(regWriteW),
		.stallF_o(stallF), .stallD_o(stallD), .bubbleE_o(bubbleE),
		.fwdAE_o(fwdAE), .fwdBE_o(fwdBE), .fwdAD_o(fwdAD), .fwdBD_o(fwdBD)
	);

	// trace follows the register file write port
	assign wbRegNum_o = writeRegW;
	assign wbData_o = resultW;

endmodule

//--- mipsCore_sva.sv
`include "cpu_params.svh"

module mipsCore_sva (
	input logic clka,
	input logic arstN_i,
	input logic stallF_i,
	input logic [`DATA_W-1:0] imemAddr_i,
	input logic [`DATA_W-1:0] dmemAddr_i,
	input logic [`DATA_W-1:0] dmemWdata_i,
	input logic dmemWe_i,
	input logic wbValid_i,
	input logic [`DATA_W-1:0] wbPc_i,
	input logic [`REG_AW-1:0] wbRegNum_i,
	input logic [`DATA_W-1:0] wbData_i
);

	// stores are word only
	storeAligned: assert property (@(posedge clka) disable iff (!arstN_i)
		dmemWe_i |-> dmemAddr_i[1:0] == 2'b00)
		else $error("store to unaligned address %h", dmemAddr_i);

	// r0 writes never show on the trace
	traceNonzero: assert property (@(posedge clka) disable iff (!arstN_i)
		wbValid_i |-> wbRegNum_i != '0)
		else $error("trace record for r0");

	// held fetch keeps its address
	fetchHeld: assert property (@(posedge clka) disable iff (!arstN_i)
		stallF_i |=> $stable(imemAddr_i))
		else $error("fetch address moved during stall");

	controlKnown: assert property (@(posedge clka) disable iff (!arstN_i)
		!$isunknown({wbValid_i, dmemWe_i, imemAddr_i, stallF_i}))
		else $error("unknown control output");

	traceKnown: assert property (@(posedge clka) disable iff (!arstN_i)
		wbValid_i |-> !$isunknown({wbPc_i, wbRegNum_i, wbData_i}))
		else $error("unknown trace record");

	storeKnown: assert property (@(posedge clka) disable iff (!arstN_i)
		dmemWe_i |-> !$isunknown({dmemAddr_i, dmemWdata_i}))
		else $error("unknown store address or data");

endmodule

bind mipsCore mipsCore_sva mipsCore_sva_inst (
	.clka(clka), .arstN_i(arstN_i), .stallF_i(stallF),
	.imemAddr_i(imemAddr_o), .dmemAddr_i(dmemAddr_o),
	.dmemWdata_i(dmemWdata_o), .dmemWe_i(dmemWe_o),
	.wbValid_i(wbValid_o), .wbPc_i(wbPc_o),
	.wbRegNum_i(wbRegNum_o), .wbData_i(wbData_o)
);

//--- mipsCore_tb.sv
`include "cpu_params.svh"

module mipsCore_tb import isa_pkg::*; ();

	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int RETIRE_TIMEOUT = 40; // cycles allowed per retirement
	// entry kinds of the program table
	localparam int NO_RECORD = 0; // retires without a trace record
	localparam int RETIRES = 1;
	localparam int SKIPPED = 2; // branch shadow that must never retire
	// the single sw of the program
	localparam logic [31:0] STORE_ADDR = 32'h0000_0044; // r13 + 4
	localparam logic [31:0] STORE_DATA = 32'h8000_8000; // r10

	logic clka, arstN;
	logic [`DATA_W-1:0] imemAddr, imemData, dmemAddr, dmemWdata, dmemRdata;
	logic [`DATA_W-1:0] wbPc, wbData;
	logic [`REG_AW-1:0] wbRegNum;
	logic dmemWe, wbValid;

	logic [31:0] imem [IMEM_WORDS];
	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] dmemInit [DMEM_WORDS]; // preload copy for expected values

	// program table with entry k at pc 4*k
	logic [31:0] progWord [$];
	int progKind [$];
	logic [`REG_AW-1:0] progReg [$];
	logic [31:0] progVal [$];

	int storeCount = 0;
	int storeErrors = 0;

	mipsCore mipsCore_inst (
		.clka(clka), .arstN_i(arstN),
		.imemAddr_o(imemAddr), .imemData_i(imemData),
		.dmemAddr_o(dmemAddr), .dmemWdata_o(dmemWdata),
		.dmemWe_o(dmemWe), .dmemRdata_i(dmemRdata),
		.wbValid_o(wbValid), .wbPc_o(wbPc),
		.wbRegNum_o(wbRegNum), .wbData_o(wbData)
	);

	initial begin
		clka = 1'b0;
		forever #4 clka = ~clka;
	end

	// ------------------------------
	// memory models
	assign imemData = (imemAddr[31:8] == '0) ? imem[imemAddr[7:2]] : 32'h0; // nop past the program
	assign dmemRdata = dmem[dmemAddr[7:2]];

	always @(posedge clka or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < DMEM_WORDS; k++) begin
				dmem[k] <= dmemInit[k];
			end
		end else if (dmemWe) begin
			dmem[dmemAddr[7:2]] <= dmemWdata;
		end
	end

	// data bus values of every store
	always @(negedge clka) begin
		if (arstN && dmemWe) begin
			storeCount++;
			if (dmemAddr != STORE_ADDR || dmemWdata != STORE_DATA) begin
				$display("error at time %0t: store %h to %h, expected %h to %h",
					$time, dmemWdata, dmemAddr, STORE_DATA, STORE_ADDR);
				storeErrors++;
			end
		end
	end

	function automatic logic [31:0] rType(functT fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd, logic [4:0] sh);
		return {SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iType(opcodeT op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(logic [25:0] target);
		return {J, target};
	endfunction

	task automatic addStep(logic [31:0] word, int kind, logic [`REG_AW-1:0] rg,
			logic [31:0] val);
		progWord.push_back(word);
		progKind.push_back(kind);
		progReg.push_back(rg);
		progVal.push_back(val);
	endtask

	// ------------------------------
	// program with hand-worked results
	task automatic buildProgram();
		// ALU chain where each result feeds the next
		addStep(iType(ADDIU, 5'd0, 5'd1, 16'h7fff), RETIRES, 5'd1, 32'h0000_7fff);
		addStep(iType(ADDIU, 5'd1, 5'd2, 16'hffff), RETIRES, 5'd2, 32'h0000_7ffe); // imm -1
		addStep(rType(ADDU, 5'd1, 5'd2, 5'd3, 5'd0), RETIRES, 5'd3, 32'h0000_fffd);
		addStep(rType(SUBU, 5'd0, 5'd3, 5'd4, 5'd0), RETIRES, 5'd4, 32'hffff_0003); // wraps
		addStep(rType(AND, 5'd4, 5'd3, 5'd5, 5'd0), RETIRES, 5'd5, 32'h0000_0001);
		addStep(rType(OR, 5'd5, 5'd4, 5'd6, 5'd0), RETIRES, 5'd6, 32'hffff_0003);
		addStep(rType(SLT, 5'd6, 5'd5, 5'd7, 5'd0), RETIRES, 5'd7, 32'h1); // negative < 1
		addStep(rType(SLL, 5'd0, 5'd7, 5'd8, 5'd31), RETIRES, 5'd8, 32'h8000_0000);
		addStep(iType(ANDI, 5'd6, 5'd9, 16'h8003), RETIRES, 5'd9, 32'h3); // zero extended
		addStep(iType(ORI, 5'd8, 5'd10, 16'h8000), RETIRES, 5'd10, 32'h8000_8000);
		addStep(iType(ADDIU, 5'd10, 5'd0, 16'h0005), NO_RECORD, 5'd0, 32'h0); // r0 target
		addStep(rType(ADDU, 5'd10, 5'd10, 5'd11, 5'd0), RETIRES, 5'd11, 32'h0001_0000);
		addStep(rType(SLT, 5'd5, 5'd6, 5'd12, 5'd0), RETIRES, 5'd12, 32'h0);
		// store and reload with a load-use stall
		addStep(iType(ADDIU, 5'd0, 5'd13, 16'h0040), RETIRES, 5'd13, 32'h40);
		addStep(iType(SW, 5'd13, 5'd10, 16'h0004), NO_RECORD, 5'd0, 32'h0);
		addStep(iType(LW, 5'd13, 5'd14, 16'h0004), RETIRES, 5'd14, 32'h8000_8000);
		addStep(rType(ADDU, 5'd14, 5'd1, 5'd15, 5'd0), RETIRES, 5'd15, 32'h8000_ffff);
		addStep(iType(LW, 5'd13, 5'd16, 16'h0008), RETIRES, 5'd16, dmemInit[18]);
		// taken beq on a fresh operand
		addStep(iType(ADDIU, 5'd0, 5'd17, 16'h0003), RETIRES, 5'd17, 32'h3);
		addStep(iType(ADDIU, 5'd17, 5'd18, 16'h0000), RETIRES, 5'd18, 32'h3);
		addStep(iType(BEQ, 5'd17, 5'd18, 16'h0002), NO_RECORD, 5'd0, 32'h0);
		addStep(iType(ADDIU, 5'd0, 5'd19, 16'h0011), RETIRES, 5'd19, 32'h11); // delay slot
		addStep(iType(ADDIU, 5'd0, 5'd20, 16'h0022), SKIPPED, 5'd20, 32'h22);
		addStep(iType(ADDIU, 5'd19, 5'd21, 16'h0001), RETIRES, 5'd21, 32'h12);
		// not-taken bne falls through
		addStep(iType(BNE, 5'd17, 5'd18, 16'h0002), NO_RECORD, 5'd0, 32'h0);
		addStep(iType(ADDIU, 5'd0, 5'd22, 16'h0033), RETIRES, 5'd22, 32'h33);
		addStep(iType(ADDIU, 5'd0, 5'd23, 16'h0044), RETIRES, 5'd23, 32'h44);
		// j to word 30
		addStep(jType(26'd30), NO_RECORD, 5'd0, 32'h0);
		addStep(iType(ADDIU, 5'd0, 5'd24, 16'h0077), RETIRES, 5'd24, 32'h77);
		addStep(iType(ADDIU, 5'd0, 5'd25, 16'h0088), SKIPPED, 5'd25, 32'h88);
		addStep(iType(ADDIU, 5'd24, 5'd26, 16'h0100), RETIRES, 5'd26, 32'h177);
	endtask

	// next negedge with wbValid high within the cycle limit
	task automatic waitRetire(output bit seen);
		int cycles;
		cycles = 0;
		@(negedge clka);
		while (!wbValid && cycles < RETIRE_TIMEOUT) begin
			@(negedge clka);
			cycles++;
		end
		seen = wbValid;
	endtask

	// ------------------------------
	// stimulus and checks
	initial begin
		int seed;
		int errors;
		int passes;
		bit seen;
		bit resetOk;
		arstN = 1'b0;
		seed = 32'h985f107c;
		errors = 0;
		passes = 0;
		resetOk = 1'b1;
		for (int k = 0; k < DMEM_WORDS; k++) begin
			dmemInit[k] = $random(seed);
		end
		for (int k = 0; k < IMEM_WORDS; k++) begin
			imem[k] = 32'h0; // sll r0 = nop
		end
		buildProgram();
		for (int k = 0; k < progWord.size(); k++) begin
			imem[k] = progWord[k];
		end

		repeat (2) begin
			@(negedge clka);
			if (wbValid || dmemWe || imemAddr != `RESET_PC) begin
				$display("error at time %0t: outputs not idle in reset", $time);
				resetOk = 1'b0;
			end
		end
		arstN = 1'b1;
		@(negedge clka);
		if (wbValid || dmemWe || imemAddr != `RESET_PC + 32'd4) begin
			$display("error at time %0t: first cycle after reset, pc %h", $time, imemAddr);
			resetOk = 1'b0;
		end
		if (resetOk) begin
			$display("pass: reset state");
			passes++;
		end else begin
			errors++;
		end

		for (int i = 0; i < progWord.size(); i++) begin
			if (progKind[i] != RETIRES) begin
				continue;
			end
			waitRetire(seen);
			if (!seen) begin
				$display("timeout: instruction at pc %h never retired", 32'(4 * i));
				errors++;
				break;
			end
			if (wbPc != 32'(4 * i) || wbRegNum != progReg[i] || wbData != progVal[i]) begin
				$display("error at time %0t: expected pc %h r%0d = %h, got pc %h r%0d = %h",
					$time, 32'(4 * i), progReg[i], progVal[i], wbPc, wbRegNum, wbData);
				errors++;
			end else begin
				$display("pass: pc %h r%0d = %h", wbPc, wbRegNum, wbData);
				passes++;
			end
		end

		// nothing else may retire once the program drains
		repeat (8) begin
			@(negedge clka);
			if (wbValid) begin
				$display("error at time %0t: extra retirement pc %h", $time, wbPc);
				errors++;
			end
		end

		if (storeCount != 1 || storeErrors != 0) begin
			$display("store check failed: %0d stores seen where one was expected, %0d wrong",
				storeCount, storeErrors);
			errors++;
		end else begin
			$display("pass: store %h to %h", STORE_DATA, STORE_ADDR);
			passes++;
		end

		$display("checks: %0d passed, %0d failed", passes, errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

	// ALU function selected in decode, used in execute
	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt, // signed compare
		aluSll // shifts operand B by shamt
	} aluOpT;

	// operand source for the forwarding muxes
	typedef enum logic [1:0] {
		fromReg = 2'b00, // value read in decode
		fromWb = 2'b01, // result in writeback
		fromMem = 2'b10 // ALU result in memory stage
	} fwdSelT;

endpackage

//--- regFile.sv
`include "cpu_params.svh"

module regFile (
	input logic clka,
	input logic we_i,
	input logic [`REG_AW-1:0] ra1_i,
	input logic [`REG_AW-1:0] ra2_i,
	input logic [`REG_AW-1:0] wa_i,
	input logic [`DATA_W-1:0] wd_i,
	output logic [`DATA_W-1:0] rd1_o,
	output logic [`DATA_W-1:0] rd2_o
);

	logic [`DATA_W-1:0] regs [`REG_N];

	always_ff @(posedge clka) begin
		if (we_i) begin
			regs[wa_i] <= wd_i; // entry 0 is written but never read
		end
	end

	// r0 reads zero, a same-cycle write is passed straight through
	assign rd1_o = (ra1_i == '0) ? '0 : (we_i && ra1_i == wa_i) ? wd_i : regs[ra1_i];
	assign rd2_o = (ra2_i == '0) ? '0 : (we_i && ra2_i == wa_i) ? wd_i : regs[ra2_i];

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert --top-module mipsCore_tb -f sim.f -o mipsCore_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/mipsCore_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
	exit 0
fi
exit 1

//--- sim.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
instrDecoder.sv
regFile.sv
frontEnd.sv
backEnd.sv
hazardUnit.sv
mipsCore.sv
mipsCore_sva.sv
mipsCore_tb.sv
